/* hw/mips_pkg.sv */
package mips_pkg;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_addi  = 6'b001000;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	localparam logic [5:0] op_beq   = 6'b000100;
	localparam logic [5:0] op_bne   = 6'b000101;
	localparam logic [5:0] op_bgtz  = 6'b000111;
	localparam logic [5:0] op_halt  = 6'b111111;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] fn_add  = 6'b100000;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_sub  = 6'b100010;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

	// ALU operation select
	localparam logic [2:0] alu_and  = 3'd0;
	localparam logic [2:0] alu_or   = 3'd1;
	localparam logic [2:0] alu_add  = 3'd2;
	localparam logic [2:0] alu_slt  = 3'd3;
	localparam logic [2:0] alu_addu = 3'd4;
	localparam logic [2:0] alu_sll  = 3'd5;
	localparam logic [2:0] alu_sub  = 3'd6;
	localparam logic [2:0] alu_sltu = 3'd7;

	// On-chip memories, word addressed
	localparam int imem_words = 64;
	localparam int dmem_words = 64;
	localparam int imem_aw    = 6;
	localparam int dmem_aw    = 6;

	// Host register map, byte offsets
	localparam logic [11:0] reg_ctrl      = 12'h000;
	localparam logic [11:0] reg_status    = 12'h004;
	localparam logic [11:0] reg_retired   = 12'h008;
	localparam logic [11:0] reg_imem_addr = 12'h00C;
	localparam logic [11:0] reg_imem_data = 12'h010;
	localparam logic [11:0] dmem_base     = 12'h100;

	// One instruction word, seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} instr_t;

endpackage

/* hw/mips_alu.sv */
module mips_alu import mips_pkg::*; (
	input  logic [2:0]  ctrl,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] result,
	output logic        zero
);

	logic [31:0] sum;
	logic [31:0] diff;

	// No overflow traps, so signed and unsigned adds share one adder
	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		case (ctrl)
			alu_and: begin
				result = a & b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_add: begin
				result = sum;
			end
			alu_slt: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			alu_addu: begin
				result = sum;
			end
			alu_sll: begin
				// Shift source is the rt operand
				result = b << shamt;
			end
			alu_sub: begin
				result = diff;
			end
			alu_sltu: begin
				result = {31'b0, a < b};
			end
			default: begin
				result = sum;
			end
		endcase
	end

	// Equal flag for branches
	assign zero = (result == 32'b0);

endmodule

/* hw/mips_regfile.sv */
module mips_regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (we && (waddr != 5'd0)) begin
			// $zero is never written
			regs[waddr] <= wdata;
		end
	end

	// Combinational read ports
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

/* hw/mips_control.sv */
module mips_control import mips_pkg::*; (
	input  instr_t     instr,
	input  logic       equal,
	input  logic       sign,
	output logic       branch_taken,
	output logic       reg_wr,
	output logic       reg_dst,
	output logic       ext_op,
	output logic       alu_src,
	output logic [2:0] alu_ctr,
	output logic       mem_wr,
	output logic       mem_to_reg,
	output logic       is_halt
);

	logic is_beq;
	logic is_bne;
	logic is_bgtz;

	always_comb begin
		// Defaults describe a no-op
		reg_wr     = 1'b0;
		reg_dst    = 1'b0;
		ext_op     = 1'b0;
		alu_src    = 1'b0;
		alu_ctr    = alu_add;
		mem_wr     = 1'b0;
		mem_to_reg = 1'b0;
		is_beq     = 1'b0;
		is_bne     = 1'b0;
		is_bgtz    = 1'b0;
		is_halt    = 1'b0;

		case (instr.r.op)
			op_rtype: begin
				reg_dst = 1'b1;
				reg_wr  = 1'b1;
				case (instr.r.funct)
					fn_add:  alu_ctr = alu_add;
					fn_addu: alu_ctr = alu_addu;
					fn_sub:  alu_ctr = alu_sub;
					fn_subu: alu_ctr = alu_sub;
					fn_and:  alu_ctr = alu_and;
					fn_or:   alu_ctr = alu_or;
					fn_sll:  alu_ctr = alu_sll;
					fn_slt:  alu_ctr = alu_slt;
					fn_sltu: alu_ctr = alu_sltu;
					// Unknown function code writes nothing
					default: reg_wr = 1'b0;
				endcase
			end
			op_addi: begin
				reg_wr  = 1'b1;
				ext_op  = 1'b1;
				alu_src = 1'b1;
			end
			op_lw: begin
				reg_wr     = 1'b1;
				ext_op     = 1'b1;
				alu_src    = 1'b1;
				mem_to_reg = 1'b1;
			end
			op_sw: begin
				ext_op  = 1'b1;
				alu_src = 1'b1;
				mem_wr  = 1'b1;
			end
			// Branches compare rs against rt through subtraction
			op_beq: begin
				reg_dst = 1'b1;
				alu_ctr = alu_sub;
				is_beq  = 1'b1;
			end
			op_bne: begin
				reg_dst = 1'b1;
				alu_ctr = alu_sub;
				is_bne  = 1'b1;
			end
			op_bgtz: begin
				reg_dst = 1'b1;
				alu_ctr = alu_sub;
				is_bgtz = 1'b1;
			end
			op_halt: is_halt = 1'b1;
			default: ;
		endcase
	end

	// bgtz is taken when rs - rt is neither zero nor negative
	assign branch_taken = (is_beq & equal) | (is_bne & ~equal) | (is_bgtz & ~(equal | sign));

endmodule

/* hw/mips_cpu.sv */
module mips_cpu import mips_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               imem_we,
	input  logic [imem_aw-1:0] imem_waddr,
	input  logic [31:0]        imem_wdata,
	input  logic [dmem_aw-1:0] dmem_raddr,
	output logic [31:0]        dmem_rdata,
	output logic               running,
	output logic               halted,
	output logic [31:0]        retired
);

	logic [31:0] imem [imem_words];
	logic [31:0] dmem [dmem_words];

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	instr_t      instr;

	logic        branch_taken;
	logic        reg_wr;
	logic        reg_dst;
	logic        ext_op;
	logic        alu_src;
	logic [2:0]  alu_ctr;
	logic        mem_wr;
	logic        mem_to_reg;
	logic        is_halt;

	logic [4:0]  rw;
	logic [31:0] bus_a;
	logic [31:0] bus_b;
	logic [31:0] bus_w;
	logic [31:0] imm32;
	logic [31:0] br_off;
	logic [31:0] alu_b;
	logic [31:0] alu_out;
	logic        alu_zero;
	logic [31:0] load_word;
	logic        step;

	// Fetch
	assign instr    = imem[pc[imem_aw+1:2]];
	assign pc_plus4 = pc + 32'd4;

	// An instruction retires on every running edge except a halt fetch
	assign step = running & ~is_halt;

	mips_control mips_control_inst (
		.instr        (instr),
		.equal        (alu_zero),
		.sign         (alu_out[31]),
		.branch_taken (branch_taken),
		.reg_wr       (reg_wr),
		.reg_dst      (reg_dst),
		.ext_op       (ext_op),
		.alu_src      (alu_src),
		.alu_ctr      (alu_ctr),
		.mem_wr       (mem_wr),
		.mem_to_reg   (mem_to_reg),
		.is_halt      (is_halt)
	);

	assign rw = reg_dst ? instr.r.rd : instr.i.rt;

	mips_regfile mips_regfile_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (reg_wr & step),
		.waddr   (rw),
		.wdata   (bus_w),
		.raddr_a (instr.i.rs),
		.raddr_b (instr.i.rt),
		.rdata_a (bus_a),
		.rdata_b (bus_b)
	);

	// Immediate extension and branch offset
	assign imm32  = ext_op ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'b0, instr.i.imm};
	assign br_off = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
	assign alu_b  = alu_src ? imm32 : bus_b;

	mips_alu mips_alu_inst (
		.ctrl   (alu_ctr),
		.a      (bus_a),
		.b      (alu_b),
		.shamt  (instr.r.shamt),
		.result (alu_out),
		.zero   (alu_zero)
	);

	// Data memory, core port and host read port
	assign load_word  = dmem[alu_out[dmem_aw+1:2]];
	assign dmem_rdata = dmem[dmem_raddr];
	assign bus_w      = mem_to_reg ? load_word : alu_out;

	always_ff @(posedge clk) begin
		if (mem_wr && step) begin
			dmem[alu_out[dmem_aw+1:2]] <= bus_b;
		end
		if (imem_we) begin
			imem[imem_waddr] <= imem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= 32'b0;
			running <= 1'b0;
			halted  <= 1'b0;
			retired <= 32'b0;
		end else if (start) begin
			pc      <= 32'b0;
			running <= 1'b1;
			halted  <= 1'b0;
			retired <= 32'b0;
		end else if (running && is_halt) begin
			running <= 1'b0;
			halted  <= 1'b1;
		end else if (step) begin
			pc      <= branch_taken ? pc_plus4 + br_off : pc_plus4;
			retired <= retired + 32'd1;
		end
	end

endmodule

/* hw/mips_host_regs.sv */
module mips_host_regs import mips_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [11:0]        awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  logic [31:0]        wdata,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  logic [11:0]        araddr,
	input  logic               arvalid,
	output logic               arready,
	output logic [31:0]        rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	input  logic [31:0]        dmem_rdata,
	input  logic               running,
	input  logic               halted,
	input  logic [31:0]        retired,
	output logic               start,
	output logic               imem_we,
	output logic [imem_aw-1:0] imem_waddr,
	output logic [31:0]        imem_wdata,
	output logic [dmem_aw-1:0] dmem_raddr
);

	logic               wr_fire;
	logic               rd_fire;
	logic [imem_aw-1:0] load_ptr;
	logic               rd_dmem;
	logic [31:0]        rd_word;

	// Write path takes AW and W together, only with no response pending
	assign wr_fire = awvalid & wvalid & ~bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign bresp   = 2'b00;

	// Instruction load goes straight to the memory port
	assign imem_we    = wr_fire & (awaddr == reg_imem_data);
	assign imem_waddr = load_ptr;
	assign imem_wdata = wdata;

	// One read outstanding at a time
	assign arready = ~rvalid;
	assign rd_fire = arvalid & ~rvalid;
	assign rresp   = 2'b00;

	// Word index of a data memory read
	assign dmem_raddr = araddr[dmem_aw+1:2];
	assign rd_dmem    = (araddr[11:8] == dmem_base[11:8]);

	always_comb begin
		case (araddr)
			reg_status: begin
				rd_word = {30'b0, running, halted};
			end
			reg_retired: begin
				rd_word = retired;
			end
			default: begin
				rd_word = rd_dmem ? dmem_rdata : 32'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid   <= 1'b0;
			rvalid   <= 1'b0;
			start    <= 1'b0;
			load_ptr <= '0;
		end else begin
			// Single cycle pulse per ctrl write with bit 0 set
			start <= wr_fire & (awaddr == reg_ctrl) & wdata[0];

			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end

			// Pointer is a word index into instruction memory
			if (wr_fire && (awaddr == reg_imem_addr)) begin
				load_ptr <= wdata[imem_aw-1:0];
			end else if (imem_we) begin
				load_ptr <= load_ptr + imem_aw'(1);
			end

			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Read data held until the host takes it
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_word;
		end
	end

endmodule

/* hw/mips_system.sv */
module mips_system import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [11:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [11:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	logic               start;
	logic               imem_we;
	logic [imem_aw-1:0] imem_waddr;
	logic [31:0]        imem_wdata;
	logic [dmem_aw-1:0] dmem_raddr;
	logic [31:0]        dmem_rdata;
	logic               running;
	logic               halted;
	logic [31:0]        retired;

	mips_host_regs mips_host_regs_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.dmem_rdata (dmem_rdata),
		.running    (running),
		.halted     (halted),
		.retired    (retired),
		.start      (start),
		.imem_we    (imem_we),
		.imem_waddr (imem_waddr),
		.imem_wdata (imem_wdata),
		.dmem_raddr (dmem_raddr)
	);

	mips_cpu mips_cpu_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.imem_we    (imem_we),
		.imem_waddr (imem_waddr),
		.imem_wdata (imem_wdata),
		.dmem_raddr (dmem_raddr),
		.dmem_rdata (dmem_rdata),
		.running    (running),
		.halted     (halted),
		.retired    (retired)
	);

endmodule

/* bench/mips_system_tb.sv */
module mips_system_tb import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam string tests_file      = "bench/mips_tests.txt";
	localparam int    clk_period      = 100;
	localparam int    cycles_per_line = 2000;

	logic        clk;
	logic        rst_n;
	logic [11:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [11:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	integer seed;
	int     num_lines = 0;

	mips_system mips_system_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	// Budget grows with the number of lines in the data file
	initial begin
		wait (num_lines > 0);
		repeat (num_lines * cycles_per_line) begin
			@(posedge clk);
		end
		$display("Watchdog expired after %0d cycles, the test run did not finish",
			num_lines * cycles_per_line);
		$display("TB FAILED");
		$fatal(1, "Timeout");
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error at %0d ns: %s expected %08h, actual %08h",
				$time, name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic require_args(input integer got, input integer want);
		if (got != want) begin
			$display("Malformed line in the test file, expected %0d argument(s)", want);
			$display("TB FAILED");
			$fatal(1, "Bad test file");
		end
	endtask

	task automatic count_lines(output int lines);
		integer fd;
		integer ch;
		lines = 0;
		fd = $fopen(tests_file, "r");
		if (fd == 0) begin
			$display("Could not open the test file %s", tests_file);
			$display("TB FAILED");
			$fatal(1, "Missing test file");
		end
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == 10) begin
				lines++;
			end
			ch = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// Ready lines are sampled mid-cycle, after the negedge drive has settled
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
		int delay;
		@(negedge clk);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wvalid  = 1'b1;
		#(clk_period / 4);
		while (!awready) begin
			@(negedge clk);
			#(clk_period / 4);
		end
		check_value("wready", 32'd1, {31'b0, wready});
		@(negedge clk);
		// Response pending, so the same AW and W must now be refused
		check_value("bvalid", 32'd1, {31'b0, bvalid});
		check_value("awready", 32'd0, {31'b0, awready});
		check_value("wready", 32'd0, {31'b0, wready});
		check_value("bresp", 32'd0, {30'b0, bresp});
		awvalid = 1'b0;
		wvalid  = 1'b0;
		delay = {$random(seed)} % 4;
		repeat (delay) begin
			@(negedge clk);
			check_value("bvalid", 32'd1, {31'b0, bvalid});
		end
		bready = 1'b1;
		@(negedge clk);
		while (bvalid) begin
			@(negedge clk);
		end
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
		int delay;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		#(clk_period / 4);
		while (!arready) begin
			@(negedge clk);
			#(clk_period / 4);
		end
		@(negedge clk);
		check_value("rvalid", 32'd1, {31'b0, rvalid});
		check_value("arready", 32'd0, {31'b0, arready});
		check_value("rresp", 32'd0, {30'b0, rresp});
		data    = rdata;
		arvalid = 1'b0;
		// Address is free to move once the read is taken
		araddr  = ~addr;
		delay = {$random(seed)} % 4;
		repeat (delay) begin
			@(negedge clk);
			check_value("rvalid", 32'd1, {31'b0, rvalid});
		end
		// Read data must hold while rready stays low
		check_value("rdata", data, rdata);
		rready = 1'b1;
		@(negedge clk);
		while (rvalid) begin
			@(negedge clk);
		end
		rready = 1'b0;
	endtask

	task automatic run_program();
		logic [31:0] status;
		axi_write(reg_ctrl, 32'd1);
		status = 32'd0;
		while (status[0] == 1'b0) begin
			axi_read(reg_status, status);
			// After start the core is running or halted, never both or neither
			check_value("status", status[0] ? 32'd1 : 32'd2, status);
		end
	endtask

	task automatic run_test_file();
		integer       fd;
		integer       code;
		integer       ch;
		logic [127:0] cmd;
		logic [31:0]  arg_a;
		logic [31:0]  arg_b;
		logic [31:0]  value;
		logic [11:0]  addr;
		bit           done;
		fd = $fopen(tests_file, "r");
		if (fd == 0) begin
			$display("Could not open the test file %s", tests_file);
			$display("TB FAILED");
			$fatal(1, "Missing test file");
		end
		done = 1'b0;
		while (!done) begin
			arg_a = 32'd0;
			arg_b = 32'd0;
			code  = $fscanf(fd, "%s", cmd);
			if (code != 1) begin
				done = 1'b1;
			end else if (cmd == 128'("#")) begin
				// Rest of the line is a comment
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (cmd == 128'("load")) begin
				code = $fscanf(fd, "%d", arg_a);
				require_args(code, 1);
				axi_write(reg_imem_addr, arg_a);
			end else if (cmd == 128'("instr")) begin
				code = $fscanf(fd, "%h", arg_a);
				require_args(code, 1);
				axi_write(reg_imem_data, arg_a);
			end else if (cmd == 128'("run")) begin
				run_program();
			end else if (cmd == 128'("expect_mem")) begin
				code = $fscanf(fd, "%d %h", arg_a, arg_b);
				require_args(code, 2);
				addr = dmem_base + 12'(arg_a << 2);
				axi_read(addr, value);
				check_value($sformatf("dmem[%0d]", arg_a), arg_b, value);
			end else if (cmd == 128'("expect_retired")) begin
				code = $fscanf(fd, "%d", arg_a);
				require_args(code, 1);
				axi_read(reg_retired, value);
				check_value("retired", arg_a, value);
			end else if (cmd == 128'("expect_status")) begin
				code = $fscanf(fd, "%h", arg_a);
				require_args(code, 1);
				axi_read(reg_status, value);
				check_value("status", arg_a, value);
			end else if (cmd == 128'("expect_read")) begin
				code = $fscanf(fd, "%h %h", arg_a, arg_b);
				require_args(code, 2);
				axi_read(arg_a[11:0], value);
				check_value($sformatf("rdata at 0x%03h", arg_a[11:0]), arg_b, value);
			end else begin
				$display("Unknown command %0s in the test file", cmd);
				$display("TB FAILED");
				$fatal(1, "Bad test file");
			end
		end
		$fclose(fd);
	endtask

	initial begin
		seed    = 32'h35ca_f1d8;
		rst_n   = 1'b0;
		awaddr  = 12'h000;
		awvalid = 1'b0;
		wdata   = 32'd0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = 12'h000;
		arvalid = 1'b0;
		rready  = 1'b0;
		count_lines(num_lines);
		repeat (16) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst_n = 1'b1;
		run_test_file();
		$display("TB PASSED");
		$finish;
	end

endmodule

/* mips_core.f */
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_control.sv
hw/mips_cpu.sv
hw/mips_host_regs.sv
hw/mips_system.sv
bench/mips_system_tb.sv

/* Makefile */
# Verilator build and run of the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= mips_system_tb
FILELIST  ?= mips_core.f
TESTS     ?= bench/mips_tests.txt
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The testbench reads its data file relative to the project root
run: $(SIM_BIN) $(TESTS)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* bench/mips_tests.txt */
# Host commands, one per line: load <index dec> | instr <word hex> | run
# expect_mem <index dec> <word hex> | expect_retired <count dec> | expect_status <hex>
# expect_read <byte addr hex> <word hex> | a lone # starts a comment

# Straight after reset, plus unmapped reads
expect_status 0
expect_retired 0
expect_read 014 0
expect_read 0fc 0

# Arithmetic and logic, every result stored to dmem
load 0
instr 20010005  # addi $1, $0, 5
instr 2002fffd  # addi $2, $0, -3
instr 00221820  # add  $3, $1, $2
instr ac030000  # sw   $3, 0($0)
instr 00422021  # addu $4, $2, $2
instr ac040004  # sw   $4, 4($0)
instr 00222822  # sub  $5, $1, $2
instr ac050008  # sw   $5, 8($0)
instr 00413023  # subu $6, $2, $1
instr ac06000c  # sw   $6, 12($0)
instr 00443824  # and  $7, $2, $4
instr ac070010  # sw   $7, 16($0)
instr 00254025  # or   $8, $1, $5
instr ac080014  # sw   $8, 20($0)
instr 00014900  # sll  $9, $1, 4
instr ac090018  # sw   $9, 24($0)
instr 0041502a  # slt  $10, $2, $1
instr ac0a001c  # sw   $10, 28($0)
instr 0041582b  # sltu $11, $2, $1
instr ac0b0020  # sw   $11, 32($0)
instr 0022602b  # sltu $12, $1, $2
instr ac0c0024  # sw   $12, 36($0)
instr 20000007  # addi $0, $0, 7
instr ac000028  # sw   $0, 40($0)
instr ffffffff  # halt
run
expect_status 1
expect_retired 24
expect_mem 0 00000002
expect_mem 1 fffffffa
expect_mem 2 00000008
expect_mem 3 fffffff8
expect_mem 4 fffffff8
expect_mem 5 0000000d
expect_mem 6 00000050
expect_mem 7 00000001
expect_mem 8 00000000
expect_mem 9 00000001
expect_mem 10 00000000

# Counted loop with lw and branches, loaded over the first program
load 0
instr 20010003  # addi $1, $0, 3
instr ac010030  # sw   $1, 48($0)
instr 8c020030  # lw   $2, 48($0)
instr 20030000  # addi $3, $0, 0
instr 00621820  # loop add $3, $3, $2
instr 2042ffff  # addi $2, $2, -1
instr 1c40fffd  # bgtz $2, loop
instr ac030034  # sw   $3, 52($0)
instr 20040001  # addi $4, $0, 1
instr 10400001  # beq  $2, $0, +1 taken
instr 2004004d  # addi $4, $0, 77 skipped
instr 14640001  # bne  $3, $4, +1 taken
instr 20040058  # addi $4, $0, 88 skipped
instr ac040038  # sw   $4, 56($0)
instr 14400001  # bne  $2, $0, +1 not taken
instr 20840010  # addi $4, $4, 16
instr ac040000  # sw   $4, 0($0)
instr ffffffff  # halt
run
expect_status 1
expect_retired 21
expect_mem 0 00000011
expect_mem 1 fffffffa
expect_mem 12 00000003
expect_mem 13 00000006
expect_mem 14 00000001
expect_read 200 0
